//--- verilog.f
src/axil_bus_pkg.sv
src/fir_regmap_pkg.sv
src/reg_access_if.sv
src/axil_slave_port.sv
src/fir_ctrl_regs.sv
src/tap_ram_access.sv
src/fir_axil_cfg.sv
verif/tap_ram_model.sv
verif/fir_axil_cfg_tb.sv

//--- verif/fir_axil_cfg_tb.sv
/*
 * testbench for the fir axi-lite configuration slave
 * directed tests over registers, tap window, run handover and back-pressure
 */

`timescale 1ns/1ps

module fir_axil_cfg_tb;
    import axil_bus_pkg::*;
    import fir_regmap_pkg::*;

    localparam int NUM_TAPS   = 11;
    localparam int IDX_W      = $clog2(NUM_TAPS);
    localparam int MAX_CYCLES = 2000;

    logic             axis_clk;
    logic             axis_rst_n;
    logic             awvalid, awready, wvalid, wready;
    addr_t            awaddr;
    data_t            wdata;
    logic             arvalid, arready, rvalid, rready;
    addr_t            araddr;
    data_t            rdata;
    logic [3:0]       tap_we;
    logic             tap_en;
    data_t            tap_di, tap_do;
    addr_t            tap_a;
    logic             ap_start, ap_done, ap_idle;
    data_t            data_length;
    logic [IDX_W-1:0] fir_raddr;

    int    err_data;
    int    err_ctrl;
    int    err_bit;
    int    cycles;
    logic  engine_on;
    data_t cur_len;
    data_t coef [NUM_TAPS];

    fir_axil_cfg #(.NUM_TAPS(NUM_TAPS)) dut0 (.*);

    tap_ram_model ram0 (
        .axis_clk (axis_clk),
        .we       (tap_we),
        .en       (tap_en),
        .di       (tap_di),
        .a        (tap_a),
        .dout     (tap_do)
    );

    initial begin
        axis_clk = 1'b0;
        forever #4 axis_clk = ~axis_clk;
    end

    // run limit
    always @(posedge axis_clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, test did not complete", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    // engine stub, walks the tap index once started
    always @(posedge axis_clk) begin
        #1;
        if (ap_start) begin
            ap_idle   = 1'b0;
            engine_on = 1'b1;
            fir_raddr = '0;
        end else if (engine_on) begin
            fir_raddr = (fir_raddr == NUM_TAPS - 1) ? '0 : fir_raddr + 1'b1;
        end
    end

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            err_data++;
            $display("Fail %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_ctrl(input ctrl_word_u got, input ctrl_word_u exp, input string what);
        if (got.f.start !== exp.f.start || got.f.done !== exp.f.done ||
            got.f.idle !== exp.f.idle) begin
            err_ctrl++;
            $display("Fail %0t: %s, got s/d/i %b%b%b expected %b%b%b", $time, what,
                     got.f.start, got.f.done, got.f.idle,
                     exp.f.start, exp.f.done, exp.f.idle);
        end
    endtask

    task automatic check_bit(input bit got, input bit exp, input string what);
        if (got !== exp) begin
            err_bit++;
            $display("Fail %0t: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    // called 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic axil_write(input addr_t addr, input data_t data);
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = data;
        @(negedge axis_clk);
        while (!awready) @(negedge axis_clk);
        check_bit(wready, 1'b1, "wready with awready");
        @(posedge axis_clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    // lat counts edges from acceptance to rvalid, rready left high
    task automatic axil_read(input addr_t addr, output data_t data, output int lat);
        arvalid = 1'b1;
        araddr  = addr;
        @(negedge axis_clk);
        while (!arready) @(negedge axis_clk);
        @(posedge axis_clk);
        #1;
        arvalid = 1'b0;
        lat = 1;
        @(negedge axis_clk);
        while (!rvalid) begin
            lat++;
            @(negedge axis_clk);
        end
        data = rdata;
        @(posedge axis_clk);
        #1;
    endtask

    task automatic engine_done;
        ap_done = 1'b1;
        ap_idle = 1'b1;
        @(posedge axis_clk);
        #1;
        ap_done = 1'b0;
    endtask

    task automatic reset_values;
        data_t      d;
        int         lat;
        ctrl_word_u exp_c;
        ctrl_word_u got_c;
        @(negedge axis_clk);
        check_bit(awready, 1'b0, "awready after reset");
        check_bit(wready, 1'b0, "wready after reset");
        check_bit(arready, 1'b0, "arready after reset");
        check_bit(rvalid, 1'b0, "rvalid after reset");
        check_bit(ap_start, 1'b0, "ap_start after reset");
        check_bit(tap_en, 1'b0, "tap_en after reset");
        check_bit(|tap_we, 1'b0, "tap_we after reset");
        @(posedge axis_clk);
        #1;
        axil_read(LEN_OFS, d, lat);
        check_data(d, '0, "length after reset");
        axil_read(CTRL_OFS, d, lat);
        got_c.raw    = d;
        exp_c.raw    = '0;
        exp_c.f.idle = ap_idle;
        check_ctrl(got_c, exp_c, "control after reset");
    endtask

    task automatic length_rw;
        data_t d;
        int    lat;
        addr_t holes [3];
        holes = '{12'h004, 12'h100, 12'hFFC};
        repeat (4) begin
            cur_len = $urandom;
            axil_write(LEN_OFS, cur_len);
            check_data(data_length, cur_len, "data_length output");
            axil_read(LEN_OFS, d, lat);
            check_data(d, cur_len, "length read-back");
            check_bit(lat == 1, 1'b1, "length read latency of 1");
        end
        // unmapped space reads as zero
        foreach (holes[i]) begin
            axil_read(holes[i], d, lat);
            check_data(d, '0, "unmapped read");
        end
    endtask

    task automatic tap_window_rw;
        data_t d;
        int    lat;
        for (int i = 0; i < NUM_TAPS; i++) begin
            coef[i] = $urandom;
            axil_write(addr_t'(TAP_BASE + 4 * i), coef[i]);
            check_data(ram0.mem[i], coef[i], "tap ram contents");
        end
        for (int i = 0; i < NUM_TAPS; i++) begin
            axil_read(addr_t'(TAP_BASE + 4 * i), d, lat);
            check_data(d, coef[i], "tap read-back");
            check_bit(lat == 2, 1'b1, "tap read latency of 2");
        end
    endtask

    task automatic start_and_busy;
        data_t      d;
        int         lat;
        data_t      new_len;
        ctrl_word_u exp_c;
        ctrl_word_u got_c;
        new_len = $urandom_range(1, 4096);
        axil_write(CTRL_OFS, 32'h1);
        @(negedge axis_clk);
        check_bit(ap_start, 1'b1, "ap_start after start write");
        @(posedge axis_clk);
        #1;
        @(negedge axis_clk);
        check_bit(ap_start, 1'b0, "ap_start lasts one cycle");
        // engine owns the ram port
        repeat (4) begin
            check_data(tap_a, data_t'(fir_raddr) << 2, "tap_a follows fir_raddr");
            check_bit(tap_en, 1'b1, "tap_en while busy");
            check_bit(|tap_we, 1'b0, "tap_we while busy");
            @(negedge axis_clk);
        end
        @(posedge axis_clk);
        #1;
        axil_read(TAP_BASE, d, lat);
        check_data(d, INVALID_DATA, "tap read while busy");
        check_bit(lat == 2, 1'b1, "busy tap read latency");
        // write held off until the run ends
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = LEN_OFS;
        wdata   = new_len;
        repeat (3) begin
            @(negedge axis_clk);
            check_bit(awready, 1'b0, "awready while busy");
            check_bit(wready, 1'b0, "wready while busy");
        end
        @(posedge axis_clk);
        #1;
        engine_done();
        // registered done is up for this one cycle
        axil_read(CTRL_OFS, d, lat);
        awvalid      = 1'b0;
        wvalid       = 1'b0;
        got_c.raw    = d;
        exp_c.raw    = '0;
        exp_c.f.done = 1'b1;
        exp_c.f.idle = 1'b1;
        check_ctrl(got_c, exp_c, "control after ap_done");
        cur_len = new_len;
        check_data(data_length, cur_len, "write taken after run");
        for (int i = 0; i < 3; i++) begin
            axil_read(addr_t'(TAP_BASE + 4 * i), d, lat);
            check_data(d, coef[i], "tap read after run");
        end
    endtask

    task automatic read_backpressure;
        int    hold;
        data_t held;
        hold    = $urandom_range(1, 5);
        rready  = 1'b0;
        arvalid = 1'b1;
        araddr  = LEN_OFS;
        @(negedge axis_clk);
        while (!arready) @(negedge axis_clk);
        @(posedge axis_clk);
        #1;
        // arvalid kept up as a second request
        @(negedge axis_clk);
        while (!rvalid) @(negedge axis_clk);
        held = rdata;
        check_data(held, cur_len, "length under back-pressure");
        repeat (hold) begin
            @(posedge axis_clk);
            #1;
            @(negedge axis_clk);
            check_bit(rvalid, 1'b1, "rvalid held");
            check_data(rdata, held, "rdata held");
            check_bit(arready, 1'b0, "arready while response pending");
        end
        @(posedge axis_clk);
        #1;
        rready = 1'b1;
        @(negedge axis_clk);
        check_bit(arready, 1'b1, "arready as response is taken");
        @(posedge axis_clk);
        #1;
        arvalid = 1'b0;
        @(negedge axis_clk);
        while (!rvalid) @(negedge axis_clk);
        check_data(rdata, cur_len, "second read after back-pressure");
        @(posedge axis_clk);
        #1;
    endtask

    initial begin
        void'($urandom(96));
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        wvalid     = 1'b0;
        awaddr     = '0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b1;
        ap_done    = 1'b0;
        ap_idle    = 1'b1;
        fir_raddr  = '0;
        engine_on  = 1'b0;
        cur_len    = '0;
        repeat (4) @(posedge axis_clk);
        #1;
        axis_rst_n = 1'b1;

        reset_values();
        length_rw();
        tap_window_rw();
        start_and_busy();
        read_backpressure();

        $display("errors: data %0d, control %0d, bit %0d", err_data, err_ctrl, err_bit);
        if (err_data + err_ctrl + err_bit == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- verif/tap_ram_model.sv
/*
 * behavioral tap coefficient ram
 * single port, byte write enables, one cycle of read latency
 */

`timescale 1ns/1ps

module tap_ram_model #(
    parameter int DEPTH = 64
) (
    input  logic                axis_clk,
    input  logic [3:0]          we,
    input  logic                en,
    input  axil_bus_pkg::data_t di,
    input  axil_bus_pkg::addr_t a,
    output axil_bus_pkg::data_t dout
);
    import axil_bus_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    data_t             mem [0:DEPTH-1];
    logic [IDX_W-1:0]  idx;

    // byte address to word index
    assign idx = a[IDX_W+1:2];

    always_ff @(posedge axis_clk) begin
        if (en) begin
            for (int b = 0; b < 4; b++) begin
                if (we[b]) begin
                    mem[idx][8*b +: 8] <= di[8*b +: 8];
                end
            end
            // read first, old word on a write
            dout <= mem[idx];
        end
    end

endmodule

//--- src/fir_axil_cfg.sv
/*
 * axi-lite configuration slave of the fir accelerator
 * control and length registers, tap ram window and ram handover
 */

`timescale 1ns/1ps

module fir_axil_cfg #(
    parameter int  NUM_TAPS = 11,
    localparam int IDX_W    = $clog2(NUM_TAPS)
) (
    input  logic                axis_clk,
    input  logic                axis_rst_n,

    // axi-lite write side
    input  logic                awvalid,
    output logic                awready,
    input  axil_bus_pkg::addr_t awaddr,
    input  logic                wvalid,
    output logic                wready,
    input  axil_bus_pkg::data_t wdata,

    // axi-lite read side
    input  logic                arvalid,
    output logic                arready,
    input  axil_bus_pkg::addr_t araddr,
    output logic                rvalid,
    input  logic                rready,
    output axil_bus_pkg::data_t rdata,

    // tap coefficient ram
    output logic [3:0]          tap_we,
    output logic                tap_en,
    output axil_bus_pkg::data_t tap_di,
    output axil_bus_pkg::addr_t tap_a,
    input  axil_bus_pkg::data_t tap_do,

    // fir engine
    output logic                ap_start,
    input  logic                ap_done,
    input  logic                ap_idle,
    output axil_bus_pkg::data_t data_length,
    input  logic [IDX_W-1:0]    fir_raddr
);

    reg_access_if ra_if ();

    // bus side, handshakes and decode
    axil_slave_port u_port (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .awready    (awready),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .bus        (ra_if.port)
    );

    // start/done/idle, length, run state
    fir_ctrl_regs u_ctrl (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .ap_done     (ap_done),
        .ap_idle     (ap_idle),
        .ap_start    (ap_start),
        .data_length (data_length),
        .bus         (ra_if.ctrl)
    );

    // tap ram port, shared with the engine
    tap_ram_access #(
        .NUM_TAPS (NUM_TAPS)
    ) u_tap (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .fir_raddr  (fir_raddr),
        .tap_do     (tap_do),
        .tap_we     (tap_we),
        .tap_en     (tap_en),
        .tap_di     (tap_di),
        .tap_a      (tap_a),
        .bus        (ra_if.tap)
    );

endmodule

//--- src/tap_ram_access.sv
/*
 * tap coefficient ram port driver
 * serves bus tap writes and reads while ready, hands the port to the
 * fir engine index while a run is busy
 */

`timescale 1ns/1ps

module tap_ram_access #(
    parameter int  NUM_TAPS = 11,
    localparam int IDX_W    = $clog2(NUM_TAPS)
) (
    input  logic                axis_clk,
    input  logic                axis_rst_n,
    input  logic [IDX_W-1:0]    fir_raddr,
    input  axil_bus_pkg::data_t tap_do,
    output logic [3:0]          tap_we,
    output bit                  tap_en,
    output axil_bus_pkg::data_t tap_di,
    output axil_bus_pkg::addr_t tap_a,
    reg_access_if.tap           bus
);
    import axil_bus_pkg::*;
    import fir_regmap_pkg::*;

    logic  bus_wr;
    logic  bus_rd;
    logic  rd_q;
    logic  rd_inv_q;
    addr_t eng_addr;

    assign bus_wr = bus.wr_stb && (bus.wr_region == REG_TAP);
    assign bus_rd = bus.rd_stb && (bus.rd_region == REG_TAP);

    // engine index to byte address, one word per tap
    always_comb begin
        eng_addr = '0;
        eng_addr[IDX_W+1:0] = {fir_raddr, 2'b00};
    end

    always_comb begin
        if (bus.busy) begin
            // engine owns the port, read only
            tap_en = 1'b1;
            tap_we = 4'b0000;
            tap_a  = eng_addr;
            tap_di = '0;
        end else begin
            // bus access, write and read never share a cycle
            tap_en = bus_wr || bus_rd;
            tap_we = bus_wr ? 4'b1111 : 4'b0000;
            tap_a  = bus_wr ? bus.wr_offset : bus.rd_offset;
            tap_di = bus_wr ? bus.wr_data : '0;
        end
    end

    // ram has one cycle of read latency
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            rd_q     <= 1'b0;
            rd_inv_q <= 1'b0;
        end else begin
            rd_q     <= bus_rd;
            // ram was busy with the engine, data not ours
            rd_inv_q <= bus_rd && bus.busy;
        end
    end

    assign bus.tap_rvalid = rd_q;
    assign bus.tap_rdata  = rd_inv_q ? INVALID_DATA : tap_do;

endmodule

//--- src/fir_ctrl_regs.sv
/*
 * fir control registers
 * start/done/idle bits, sample length and the ready/busy run state
 */

`timescale 1ns/1ps

module fir_ctrl_regs (
    input  logic                axis_clk,
    input  logic                axis_rst_n,
    input  bit                  ap_done,
    input  bit                  ap_idle,
    output bit                  ap_start,
    output axil_bus_pkg::data_t data_length,
    reg_access_if.ctrl          bus
);
    import axil_bus_pkg::*;
    import fir_regmap_pkg::*;

    // run state, no separate idle state after reset
    typedef enum logic {
        ST_READY,
        ST_BUSY
    } run_state_t;

    run_state_t state;
    logic       start_q;
    logic       done_q;
    logic       idle_q;
    data_t      length_q;
    logic       ctrl_wr;
    logic       len_wr;
    logic       start_req;
    ctrl_word_u word_c;

    assign ctrl_wr   = bus.wr_stb && (bus.wr_region == REG_CTRL);
    assign len_wr    = bus.wr_stb && (bus.wr_region == REG_LEN);

    // only bit 0 of a control write means anything
    assign start_req = ctrl_wr && bus.wr_data[0];

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state    <= ST_READY;
            start_q  <= 1'b0;
            done_q   <= 1'b0;
            idle_q   <= 1'b0;
            length_q <= '0;
        end else begin
            // engine status, one cycle late
            done_q <= ap_done;
            idle_q <= ap_idle;

            // single cycle start pulse, next cycle is already busy
            start_q <= (state == ST_READY) && start_req;

            if (len_wr) begin
                length_q <= bus.wr_data;
            end

            case (state)
                ST_READY: begin
                    if (start_req) begin
                        state <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    // registered done ends the run
                    if (done_q) begin
                        state <= ST_READY;
                    end
                end
                default: begin
                    state <= ST_READY;
                end
            endcase
        end
    end

    // control word for read back
    always_comb begin
        word_c.f.rsvd  = '0;
        word_c.f.idle  = idle_q;
        word_c.f.done  = done_q;
        word_c.f.start = start_q;
    end

    assign bus.ctrl_word = word_c;
    assign bus.length    = length_q;
    assign bus.busy      = (state == ST_BUSY);

    assign ap_start    = start_q;
    assign data_length = length_q;

endmodule

//--- src/axil_slave_port.sv
/*
 * axi-lite slave port of the fir configuration block
 * write/read handshakes, address decode into regions, and the read
 * response register with its hold under back-pressure
 */

`timescale 1ns/1ps

module axil_slave_port (
    input  logic                axis_clk,
    input  logic                axis_rst_n,
    input  bit                  awvalid,
    input  axil_bus_pkg::addr_t awaddr,
    input  bit                  wvalid,
    input  axil_bus_pkg::data_t wdata,
    output bit                  awready,
    output bit                  wready,
    input  bit                  arvalid,
    input  axil_bus_pkg::addr_t araddr,
    output bit                  arready,
    output bit                  rvalid,
    input  bit                  rready,
    output axil_bus_pkg::data_t rdata,
    reg_access_if.port          bus
);
    import axil_bus_pkg::*;
    import fir_regmap_pkg::*;

    // read transaction state, only one read in flight
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_WAIT,
        RD_RESP
    } rd_state_t;

    rd_state_t rd_state;
    data_t     rdata_q;
    logic      wr_acc;
    logic      rd_acc;
    logic      rd_free;
    region_t   ar_region;

    // map a byte address onto the register regions
    function automatic region_t decode(input addr_t addr);
        region_t r;
        if (addr == CTRL_OFS) begin
            r = REG_CTRL;
        end else if (addr == LEN_OFS) begin
            r = REG_LEN;
        end else if (addr >= TAP_BASE && addr <= TAP_LAST) begin
            r = REG_TAP;
        end else begin
            r = REG_NONE;
        end
        return r;
    endfunction

    // address and data must arrive together, nothing taken during a run
    assign wr_acc  = awvalid && wvalid && !bus.busy;
    assign awready = wr_acc;
    assign wready  = wr_acc;

    // write strobe goes straight to the targets
    assign bus.wr_stb    = wr_acc;
    assign bus.wr_region = decode(awaddr);
    assign bus.wr_offset = awaddr - TAP_BASE;
    assign bus.wr_data   = wdata;

    // slot frees up when the held response is taken this cycle
    assign rd_free = (rd_state == RD_IDLE) || (rd_state == RD_RESP && rready);

    // writes win the tap ram port, so no read accept next to one
    assign arready = arvalid && rd_free && !wr_acc;
    assign rd_acc  = arready;

    assign ar_region     = decode(araddr);
    assign bus.rd_stb    = rd_acc;
    assign bus.rd_region = ar_region;
    assign bus.rd_offset = araddr - TAP_BASE;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            rd_state <= RD_IDLE;
        end else begin
            case (rd_state)
                // ram data comes back one cycle after the strobe
                RD_WAIT: begin
                    if (bus.tap_rvalid) begin
                        rd_state <= RD_RESP;
                    end
                end
                // hold until the master takes it
                RD_RESP: begin
                    if (rready) begin
                        rd_state <= RD_IDLE;
                    end
                end
                default: begin
                    rd_state <= rd_state;
                end
            endcase
            // new read overrides the release above
            if (rd_acc) begin
                rd_state <= (ar_region == REG_TAP) ? RD_WAIT : RD_RESP;
            end
        end
    end

    // response word, loaded once per read and held otherwise
    always_ff @(posedge axis_clk) begin
        if (rd_acc) begin
            case (ar_region)
                REG_CTRL: rdata_q <= bus.ctrl_word.raw;
                REG_LEN:  rdata_q <= bus.length;
                // unmapped reads return 0, tap data lands a cycle later
                default:  rdata_q <= '0;
            endcase
        end else if (rd_state == RD_WAIT && bus.tap_rvalid) begin
            rdata_q <= bus.tap_rdata;
        end
    end

    assign rvalid = (rd_state == RD_RESP);
    assign rdata  = rdata_q;

endmodule

//--- src/reg_access_if.sv
/*
 * register access bundle between the axi-lite port and its targets
 * carries decoded write and read strobes plus the values read back
 */

`timescale 1ns/1ps

interface reg_access_if;
    import axil_bus_pkg::*;
    import fir_regmap_pkg::*;

    // write side, one strobe per accepted write
    logic       wr_stb;
    region_t    wr_region;
    addr_t      wr_offset;
    data_t      wr_data;

    // read side, strobe on the accepting cycle
    logic       rd_stb;
    region_t    rd_region;
    addr_t      rd_offset;

    // register contents and run state
    ctrl_word_u ctrl_word;
    data_t      length;
    logic       busy;

    // tap read return, one cycle after rd_stb
    data_t      tap_rdata;
    logic       tap_rvalid;

    modport port (
        output wr_stb, wr_region, wr_offset, wr_data,
        output rd_stb, rd_region, rd_offset,
        input  ctrl_word, length, busy, tap_rdata, tap_rvalid
    );

    modport ctrl (
        input  wr_stb, wr_region, wr_data,
        output ctrl_word, length, busy
    );

    modport tap (
        input  wr_stb, wr_region, wr_offset, wr_data,
        input  rd_stb, rd_region, rd_offset, busy,
        output tap_rdata, tap_rvalid
    );

endinterface

//--- src/fir_regmap_pkg.sv
/*
 * fir configuration register map
 * register offsets, tap window bounds, decoded region and the control word
 */

package fir_regmap_pkg;

    // control register, start/done/idle
    parameter axil_bus_pkg::addr_t CTRL_OFS = 12'h000;

    // number of samples for the next run
    parameter axil_bus_pkg::addr_t LEN_OFS  = 12'h010;

    // tap coefficient window, byte addressed
    parameter axil_bus_pkg::addr_t TAP_BASE = 12'h020;
    parameter axil_bus_pkg::addr_t TAP_LAST = 12'h0FF;

    // region an access falls into, decoded once at the bus port
    typedef enum logic [1:0] {
        REG_CTRL,
        REG_LEN,
        REG_TAP,
        REG_NONE
    } region_t;

    // field layout of the control register
    typedef struct packed {
        logic [28:0] rsvd;
        logic        idle;
        logic        done;
        logic        start;
    } ctrl_fields_t;

    // same word seen as bus data or as control fields
    typedef union packed {
        axil_bus_pkg::data_t raw;
        ctrl_fields_t        f;
    } ctrl_word_u;

endpackage

//--- src/axil_bus_pkg.sv
/*
 * axi-lite bus definitions for the fir configuration slave
 * address and data widths, word types and the invalid read word
 */

package axil_bus_pkg;

    // byte address into the 4 KB config space
    parameter int ADDR_W = 12;

    // one register or tap coefficient per beat
    parameter int DATA_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;

    typedef logic [DATA_W-1:0] data_t;

    // returned for tap reads while the engine owns the ram
    parameter data_t INVALID_DATA = 32'hFFFF_FFFF;

endpackage
